/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Bus and line geometry
    localparam int addr_width = 32;
    localparam int data_width = 64;
    localparam int beats_per_line = 8;     // One line is a single 8-beat burst
    localparam int word_sel_width = 3;
    localparam int line_offset_width = 6;  // 64-byte lines

    // data_size codes, as seen on the core side
    localparam logic [2:0] size_byte = 3'd1;
    localparam logic [2:0] size_half = 3'd2;
    localparam logic [2:0] size_word = 3'd4;
    localparam logic [2:0] size_double = 3'd7;

    // Core request, held until done
    typedef struct packed {
        logic read;
        logic write;
        logic [addr_width-1:0] addr;
        logic [2:0] size;
        logic [data_width-1:0] wdata;   // LSB aligned
    } core_req_t;

    typedef struct packed {
        logic valid;
        logic [addr_width-1:0] addr;    // Line address
    } rd_addr_t;

    typedef struct packed {
        logic valid;
        logic [data_width-1:0] data;
        logic last;
    } rd_data_t;

    typedef struct packed {
        logic valid;
        logic [addr_width-1:0] addr;
    } wr_addr_t;

    typedef struct packed {
        logic valid;
        logic [data_width-1:0] data;
        logic last;                     // Set on the eighth beat
    } wr_data_t;

endpackage

`default_nettype wire

/* design/tag_array.sv */
`default_nettype none
`timescale 1ns/100ps

module tag_array #(
    parameter int sets = 4,
    parameter int ways = 2,
    localparam int index_width = $clog2(sets),
    localparam int way_width = (ways > 1) ? $clog2(ways) : 1,
    localparam int tag_width = dcache_pkg::addr_width - index_width
                               - dcache_pkg::line_offset_width
) (
    input  logic clock,
    input  logic reset,
    input  logic [index_width-1:0] index,
    input  logic [tag_width-1:0] tag,
    output logic hit,
    output logic [way_width-1:0] hit_way,
    output logic [way_width-1:0] victim_way,
    output logic victim_dirty,
    output logic [tag_width-1:0] victim_tag,
    input  logic fill,
    input  logic [way_width-1:0] fill_way,
    input  logic mark_dirty,
    input  logic [way_width-1:0] dirty_way
);

    logic [tag_width-1:0] tags [sets][ways];
    logic [sets-1:0][ways-1:0] valid;
    logic [sets-1:0][ways-1:0] dirty;
    logic [way_width-1:0] rr_count;     // Shared round-robin pointer
    logic has_free;
    logic [way_width-1:0] free_way;

    // Match against every way of the addressed set
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                hit = 1'b1;
                hit_way = way_width'(w);
            end
        end
    end

    always_comb begin
        has_free = 1'b0;
        free_way = '0;
        for (int w = ways - 1; w >= 0; w--) begin   // Lowest invalid way wins
            if (!valid[index][w]) begin
                has_free = 1'b1;
                free_way = way_width'(w);
            end
        end
    end

    assign victim_way = has_free ? free_way : rr_count;
    assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];
    assign victim_tag = tags[index][victim_way];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            rr_count <= '0;
        end else begin
            if (fill) begin
                valid[index][fill_way] <= 1'b1;     // Installed clean
                dirty[index][fill_way] <= 1'b0;
                if (!has_free)
                    rr_count <= (rr_count == way_width'(ways - 1)) ? '0 : rr_count + 1'b1;
            end
            if (mark_dirty)
                dirty[index][dirty_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill)
            tags[index][fill_way] <= tag;
    end

endmodule

`default_nettype wire

/* design/line_store.sv */
`default_nettype none
`timescale 1ns/100ps

module line_store #(
    parameter int sets = 4,
    parameter int ways = 2,
    localparam int index_width = $clog2(sets),
    localparam int way_width = (ways > 1) ? $clog2(ways) : 1,
    localparam int bytes_per_word = dcache_pkg::data_width / 8
) (
    input  logic clock,
    input  logic [index_width-1:0] index,
    input  logic [way_width-1:0] way,
    input  logic [dcache_pkg::word_sel_width-1:0] word_sel,
    input  logic wr_en,
    input  logic [bytes_per_word-1:0] byte_mask,
    input  logic [dcache_pkg::data_width-1:0] wr_data,
    output logic [dcache_pkg::data_width-1:0] rd_data
);

    localparam int addr_bits = index_width + way_width + dcache_pkg::word_sel_width;
    localparam int depth = 2 ** addr_bits;

    // Word-wide storage, eight words per line
    logic [dcache_pkg::data_width-1:0] mem [depth];
    logic [addr_bits-1:0] addr;

    assign addr = {index, way, word_sel};

    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int b = 0; b < bytes_per_word; b++) begin
                if (byte_mask[b])
                    mem[addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
        rd_data <= mem[addr];   // Old data on a same-cycle write
    end

endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module cache_ctrl #(
    parameter int sets = 4,
    parameter int ways = 2,
    localparam int index_width = $clog2(sets),
    localparam int way_width = (ways > 1) ? $clog2(ways) : 1,
    localparam int tag_width = dcache_pkg::addr_width - index_width
                               - dcache_pkg::line_offset_width
) (
    input  logic clock,
    input  logic reset,
    input  dcache_pkg::core_req_t req,
    output logic done,
    output logic [dcache_pkg::data_width-1:0] rdata,
    input  logic ar_ready,
    output dcache_pkg::rd_addr_t rd_addr,
    input  dcache_pkg::rd_data_t rd_data,
    output logic r_ready,
    input  logic aw_ready,
    output dcache_pkg::wr_addr_t wr_addr,
    input  logic w_ready,
    output dcache_pkg::wr_data_t wr_data,
    input  logic b_valid,
    output logic b_ready,
    output logic [index_width-1:0] index,
    output logic [tag_width-1:0] tag,
    input  logic hit,
    input  logic [way_width-1:0] hit_way,
    input  logic [way_width-1:0] victim_way,
    input  logic victim_dirty,
    input  logic [tag_width-1:0] victim_tag,
    output logic fill,
    output logic [way_width-1:0] fill_way,
    output logic mark_dirty,
    output logic [way_width-1:0] dirty_way,
    output logic [way_width-1:0] way,
    output logic [dcache_pkg::word_sel_width-1:0] word_sel,
    output logic wr_en,
    output logic [7:0] byte_mask,
    output logic [dcache_pkg::data_width-1:0] wr_data_line,
    input  logic [dcache_pkg::data_width-1:0] rd_word
);

    typedef enum logic [3:0] {
        st_idle, st_lookup, st_word_read,
        st_wb_addr, st_wb_data, st_wb_resp,
        st_rf_addr, st_rf_data, st_respond
    } state_t;

    state_t state, next_state;
    logic [way_width-1:0] victim_q;
    logic [dcache_pkg::word_sel_width-1:0] beat;
    logic released;                 // Request seen low since the last access
    logic access;
    logic w_fire, r_fire;
    logic [2:0] byte_off;
    logic [5:0] bit_off;
    logic [7:0] size_mask;
    logic [dcache_pkg::data_width-1:0] shifted_word;

    assign access = req.read | req.write;
    assign index = req.addr[dcache_pkg::line_offset_width +: index_width];
    assign tag = req.addr[dcache_pkg::addr_width-1 -: tag_width];
    assign byte_off = req.addr[2:0];
    assign bit_off = {byte_off, 3'b000};

    assign w_fire = (state == st_wb_data) && w_ready;
    assign r_fire = (state == st_rf_data) && rd_data.valid;

    always_comb begin
        case (req.size)
            dcache_pkg::size_byte: size_mask = 8'h01;
            dcache_pkg::size_half: size_mask = 8'h03;
            dcache_pkg::size_word: size_mask = 8'h0f;
            default:               size_mask = 8'hff;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:      if (access && released) next_state = st_lookup;
            st_lookup: begin
                if (hit)
                    next_state = st_word_read;
                else if (victim_dirty)
                    next_state = st_wb_addr;    // Evict before the refill
                else
                    next_state = st_rf_addr;
            end
            st_word_read: next_state = st_respond;
            st_wb_addr:   if (aw_ready) next_state = st_wb_data;
            st_wb_data:   if (w_fire && beat == '1) next_state = st_wb_resp;
            st_wb_resp:   if (b_valid) next_state = st_rf_addr;
            st_rf_addr:   if (ar_ready) next_state = st_rf_data;
            st_rf_data:   if (r_fire && rd_data.last) next_state = st_lookup;
            st_respond:   next_state = st_idle;
            default:      next_state = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            beat <= '0;
            released <= 1'b1;
        end else begin
            state <= next_state;
            if (state == st_idle)
                released <= !access;
            if (state == st_lookup)
                beat <= '0;
            else if (w_fire || r_fire)
                beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_lookup)
            victim_q <= victim_way;
    end

    // Line store port, shared by hits, write-back and refill
    always_comb begin
        way = victim_q;
        word_sel = beat;
        wr_en = 1'b0;
        byte_mask = 8'hff;
        wr_data_line = rd_data.data;
        case (state)
            st_lookup: begin
                way = hit_way;
                word_sel = req.addr[dcache_pkg::line_offset_width-1 -: dcache_pkg::word_sel_width];
                wr_en = hit && req.write;
                byte_mask = size_mask << byte_off;
                wr_data_line = req.wdata << bit_off;
            end
            st_wb_data: word_sel = beat + dcache_pkg::word_sel_width'(w_fire); // Prefetch next beat
            st_rf_data: wr_en = rd_data.valid;
            default: ;
        endcase
    end

    assign fill = r_fire && rd_data.last;
    assign fill_way = victim_q;
    assign mark_dirty = (state == st_lookup) && hit && req.write;
    assign dirty_way = hit_way;

    assign shifted_word = rd_word >> bit_off;

    // Zero-extended read result
    always_ff @(posedge clock) begin
        if (state == st_word_read) begin
            case (req.size)
                dcache_pkg::size_byte: rdata <= dcache_pkg::data_width'(shifted_word[7:0]);
                dcache_pkg::size_half: rdata <= dcache_pkg::data_width'(shifted_word[15:0]);
                dcache_pkg::size_word: rdata <= dcache_pkg::data_width'(shifted_word[31:0]);
                default:               rdata <= shifted_word;
            endcase
        end
    end

    assign done = (state == st_respond);

    assign rd_addr.valid = (state == st_rf_addr);
    assign rd_addr.addr = {tag, index, {dcache_pkg::line_offset_width{1'b0}}};
    assign r_ready = (state == st_rf_data);

    assign wr_addr.valid = (state == st_wb_addr);
    assign wr_addr.addr = {victim_tag, index, {dcache_pkg::line_offset_width{1'b0}}};
    assign wr_data.valid = (state == st_wb_data);
    assign wr_data.data = rd_word;
    assign wr_data.last = (beat == '1);
    assign b_ready = (state == st_wb_resp);

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_top #(
    parameter int sets = 4,
    parameter int ways = 2,
    localparam int index_width = $clog2(sets),
    localparam int way_width = (ways > 1) ? $clog2(ways) : 1,
    localparam int tag_width = dcache_pkg::addr_width - index_width
                               - dcache_pkg::line_offset_width
) (
    input  logic clock,
    input  logic reset,
    input  dcache_pkg::core_req_t req,
    output logic done,
    output logic [dcache_pkg::data_width-1:0] rdata,
    input  logic ar_ready,
    output dcache_pkg::rd_addr_t rd_addr,
    input  dcache_pkg::rd_data_t rd_data,
    output logic r_ready,
    input  logic aw_ready,
    output dcache_pkg::wr_addr_t wr_addr,
    input  logic w_ready,
    output dcache_pkg::wr_data_t wr_data,
    input  logic b_valid,
    output logic b_ready
);

    // Tag array side
    logic [index_width-1:0] index;
    logic [tag_width-1:0] tag;
    logic hit;
    logic [way_width-1:0] hit_way;
    logic [way_width-1:0] victim_way;
    logic victim_dirty;
    logic [tag_width-1:0] victim_tag;
    logic fill;
    logic [way_width-1:0] fill_way;
    logic mark_dirty;
    logic [way_width-1:0] dirty_way;

    // Line store side
    logic [way_width-1:0] way;
    logic [dcache_pkg::word_sel_width-1:0] word_sel;
    logic wr_en;
    logic [7:0] byte_mask;
    logic [dcache_pkg::data_width-1:0] wr_data_line;
    logic [dcache_pkg::data_width-1:0] rd_word;

    tag_array #(.sets(sets), .ways(ways)) u_tag_array (
        .clock(clock), .reset(reset),
        .index(index), .tag(tag),
        .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .fill(fill), .fill_way(fill_way),
        .mark_dirty(mark_dirty), .dirty_way(dirty_way)
    );

    line_store #(.sets(sets), .ways(ways)) u_line_store (
        .clock(clock),
        .index(index), .way(way), .word_sel(word_sel),
        .wr_en(wr_en), .byte_mask(byte_mask), .wr_data(wr_data_line),
        .rd_data(rd_word)
    );

    cache_ctrl #(.sets(sets), .ways(ways)) u_cache_ctrl (
        .clock(clock), .reset(reset),
        .req(req), .done(done), .rdata(rdata),
        .ar_ready(ar_ready), .rd_addr(rd_addr),
        .rd_data(rd_data), .r_ready(r_ready),
        .aw_ready(aw_ready), .wr_addr(wr_addr),
        .w_ready(w_ready), .wr_data(wr_data),
        .b_valid(b_valid), .b_ready(b_ready),
        .index(index), .tag(tag),
        .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .fill(fill), .fill_way(fill_way),
        .mark_dirty(mark_dirty), .dirty_way(dirty_way),
        .way(way), .word_sel(word_sel),
        .wr_en(wr_en), .byte_mask(byte_mask),
        .wr_data_line(wr_data_line), .rd_word(rd_word)
    );

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
`default_nettype none
`timescale 1ns/100ps

module axi_mem_model (
    input  logic clock,
    input  logic reset,
    input  logic stalls,                // Random back-pressure when high
    output logic ar_ready,
    input  dcache_pkg::rd_addr_t rd_addr,
    output dcache_pkg::rd_data_t rd_data,
    input  logic r_ready,
    output logic aw_ready,
    input  dcache_pkg::wr_addr_t wr_addr,
    output logic w_ready,
    input  dcache_pkg::wr_data_t wr_data,
    output logic b_valid,
    input  logic b_ready
);

    logic [63:0] mem [logic [31:0]];    // Only words written back by the cache
    logic [31:0] rng;
    logic go;
    logic r_active;
    logic [31:0] r_addr;
    logic [2:0] r_beat;
    logic w_active;
    logic [31:0] w_addr;
    logic [2:0] w_beat;
    logic b_pending;
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic [31:0] ar_addr_s;
    logic [31:0] aw_addr_s;
    logic [63:0] w_data_s;

    // Unwritten words follow the address pattern
    function automatic logic [63:0] mem_read(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return {a, ~a};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One draw per channel and cycle
    task automatic roll();
        rng = lcg_next(rng);
        go = !stalls || (rng[23:22] != 2'b00);
    endtask

    task automatic clear_state();
        r_active = 1'b0;
        r_addr = '0;
        r_beat = '0;
        w_active = 1'b0;
        w_addr = '0;
        w_beat = '0;
        b_pending = 1'b0;
        ar_ready = 1'b0;
        rd_data = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
    endtask

    task automatic step();
        if (ar_hs) begin
            r_active = 1'b1;
            r_addr = ar_addr_s;
            r_beat = 3'd0;
        end else if (r_hs) begin
            r_active = (r_beat != 3'd7);
            r_beat = r_beat + 3'd1;
        end
        if (aw_hs) begin
            w_active = 1'b1;
            w_addr = aw_addr_s;
            w_beat = 3'd0;
        end else if (w_hs) begin
            mem[w_addr + 32'({w_beat, 3'b000})] = w_data_s;
            b_pending = (w_beat == 3'd7);   // Response follows the last beat
            w_active = (w_beat != 3'd7);
            w_beat = w_beat + 3'd1;
        end
        if (b_hs)
            b_pending = 1'b0;

        roll();
        ar_ready = !r_active && go;
        if (!rd_data.valid || r_hs) begin   // An unaccepted beat stays put
            roll();
            rd_data.valid = r_active && go;
        end
        rd_data.data = mem_read(r_addr + 32'({r_beat, 3'b000}));
        rd_data.last = (r_beat == 3'd7);
        roll();
        aw_ready = !w_active && !b_pending && go;
        roll();
        w_ready = w_active && go;
        if (!b_valid || b_hs) begin
            roll();
            b_valid = b_pending && go;
        end
    endtask

    initial begin
        rng = 32'h1aef854e;
        clear_state();
        forever begin
            @(negedge clock);               // Same values as just before the edge
            ar_hs = rd_addr.valid && ar_ready;
            r_hs = rd_data.valid && r_ready;
            aw_hs = wr_addr.valid && aw_ready;
            w_hs = wr_data.valid && w_ready;
            b_hs = b_valid && b_ready;
            ar_addr_s = rd_addr.addr;
            aw_addr_s = wr_addr.addr;
            w_data_s = wr_data.data;
            @(posedge clock);
            #1;
            if (reset)
                clear_state();
            else
                step();
        end
    end

endmodule

`default_nettype wire

/* sim/dcache_props.sv */
`default_nettype none
`timescale 1ns/100ps

module dcache_props (
    input logic clock,
    input logic reset,
    input logic done,
    input logic ar_ready,
    input dcache_pkg::rd_addr_t rd_addr,
    input dcache_pkg::rd_data_t rd_data,
    input logic r_ready,
    input logic aw_ready,
    input dcache_pkg::wr_addr_t wr_addr,
    input logic w_ready,
    input dcache_pkg::wr_data_t wr_data
);

    logic [2:0] r_count;
    logic [2:0] w_count;
    logic r_move;
    logic w_move;

    assign r_move = rd_data.valid && r_ready;
    assign w_move = wr_data.valid && w_ready;

    // Beat position inside the current burst
    always_ff @(posedge clock) begin
        if (reset) begin
            r_count <= '0;
            w_count <= '0;
        end else begin
            if (r_move)
                r_count <= r_count + 3'd1;
            if (w_move)
                w_count <= w_count + 3'd1;
        end
    end

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        rd_addr.valid && !ar_ready |=> rd_addr.valid && $stable(rd_addr.addr))
        else $error("Read address dropped or changed before ar_ready");

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        wr_addr.valid && !aw_ready |=> wr_addr.valid && $stable(wr_addr.addr))
        else $error("Write address dropped or changed before aw_ready");

    addr_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(rd_addr.valid && wr_addr.valid))
        else $error("Read and write address valid together");

    done_pulse: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

    r_last: assert property (@(posedge clock) disable iff (reset)
        r_move |-> (rd_data.last == (r_count == 3'd7)))
        else $error("Read last not on the eighth beat");

    w_last: assert property (@(posedge clock) disable iff (reset)
        w_move |-> (wr_data.last == (w_count == 3'd7)))
        else $error("Write last not on the eighth beat");

endmodule

bind cache_ctrl dcache_props u_dcache_props (
    .clock(clock), .reset(reset), .done(done),
    .ar_ready(ar_ready), .rd_addr(rd_addr),
    .rd_data(rd_data), .r_ready(r_ready),
    .aw_ready(aw_ready), .wr_addr(wr_addr),
    .w_ready(w_ready), .wr_data(wr_data)
);

`default_nettype wire

/* sim/tb_dcache.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_dcache;

    localparam int timeout_cycles = 2000;

    logic clock;
    logic reset;
    logic stalls;
    dcache_pkg::core_req_t req;
    logic done;
    logic [dcache_pkg::data_width-1:0] rdata;
    logic ar_ready;
    logic r_ready;
    logic aw_ready;
    logic w_ready;
    logic b_valid;
    logic b_ready;
    dcache_pkg::rd_addr_t rd_addr;
    dcache_pkg::rd_data_t rd_data;
    dcache_pkg::wr_addr_t wr_addr;
    dcache_pkg::wr_data_t wr_data;

    int errors;
    int checks;
    logic [63:0] shadow [logic [31:0]];    // Expected memory image, aligned addresses

    dcache_top #(.sets(4), .ways(2)) u_dcache_top (
        .clock(clock), .reset(reset),
        .req(req), .done(done), .rdata(rdata),
        .ar_ready(ar_ready), .rd_addr(rd_addr),
        .rd_data(rd_data), .r_ready(r_ready),
        .aw_ready(aw_ready), .wr_addr(wr_addr),
        .w_ready(w_ready), .wr_data(wr_data),
        .b_valid(b_valid), .b_ready(b_ready)
    );

    axi_mem_model u_axi_mem_model (
        .clock(clock), .reset(reset), .stalls(stalls),
        .ar_ready(ar_ready), .rd_addr(rd_addr),
        .rd_data(rd_data), .r_ready(r_ready),
        .aw_ready(aw_ready), .wr_addr(wr_addr),
        .w_ready(w_ready), .wr_data(wr_data),
        .b_valid(b_valid), .b_ready(b_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        logic [31:0] aligned;
        aligned = {addr[31:3], 3'b000};
        if (shadow.exists(aligned))
            return shadow[aligned];
        return {aligned, ~aligned};    // Untouched memory pattern
    endfunction

    function automatic int size_bytes(input logic [2:0] size);
        case (size)
            dcache_pkg::size_byte: return 1;
            dcache_pkg::size_half: return 2;
            dcache_pkg::size_word: return 4;
            default:               return 8;
        endcase
    endfunction

    // Zero-extended bytes starting at the byte offset
    function automatic logic [63:0] expected_read(input logic [31:0] addr,
                                                  input logic [2:0] size);
        logic [63:0] word;
        logic [63:0] value;
        int off;
        word = expected_word(addr);
        value = '0;
        off = int'(addr[2:0]);
        for (int i = 0; i < size_bytes(size); i++)
            value[i*8 +: 8] = word[(off + i)*8 +: 8];
        return value;
    endfunction

    task automatic store_shadow(input logic [31:0] addr, input logic [2:0] size,
                                input logic [63:0] wdata);
        logic [63:0] word;
        int off;
        word = expected_word(addr);
        off = int'(addr[2:0]);
        for (int i = 0; i < size_bytes(size); i++)
            word[(off + i)*8 +: 8] = wdata[i*8 +: 8];
        shadow[{addr[31:3], 3'b000}] = word;
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // Holds the request until done, then keeps it low for two cycles
    task automatic core_access(input logic is_write, input logic [31:0] addr,
                               input logic [2:0] size, input logic [63:0] wdata,
                               output logic [63:0] data, output int cycles);
        req.read = !is_write;
        req.write = is_write;
        req.addr = addr;
        req.size = size;
        req.wdata = wdata;
        cycles = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
        end while (!done && cycles < timeout_cycles);
        if (!done) begin
            $display("Timeout: no done from the cache for address %h", addr);
            $display("TEST FAILED");
            $finish;
        end else begin
            data = rdata;
            req = '0;
            repeat (2) @(posedge clock);
            #1;
        end
    endtask

    task automatic cache_read_check(input string name, input logic [31:0] addr,
                                    input logic [2:0] size);
        logic [63:0] data;
        int cycles;
        core_access(1'b0, addr, size, '0, data, cycles);
        compare(name, expected_read(addr, size), data);
    endtask

    task automatic cache_write(input logic [31:0] addr, input logic [2:0] size,
                               input logic [63:0] wdata);
        logic [63:0] data;
        int cycles;
        core_access(1'b1, addr, size, wdata, data, cycles);
        store_shadow(addr, size, wdata);
    endtask

    task automatic test_miss_then_hit(input logic [31:0] base);
        logic [63:0] data;
        int cycles;
        cache_read_check("miss_then_hit", base, dcache_pkg::size_double);
        cache_read_check("miss_then_hit", base + 32'h1048, dcache_pkg::size_double);
        cache_read_check("miss_then_hit", base + 32'h20d0, dcache_pkg::size_double);
        core_access(1'b0, base, dcache_pkg::size_double, '0, data, cycles);
        compare("miss_then_hit", expected_read(base, dcache_pkg::size_double), data);
        compare("miss_then_hit latency", 64'd3, 64'(cycles));
    endtask

    task automatic test_read_sizes();
        logic [2:0] codes [4];
        codes = '{dcache_pkg::size_byte, dcache_pkg::size_half,
                  dcache_pkg::size_word, dcache_pkg::size_double};
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += size_bytes(codes[s]))
                cache_read_check("read_sizes", 32'h5018 + 32'(off), codes[s]);
        end
    endtask

    task automatic test_write_merge();
        cache_read_check("write_merge", 32'h6010, dcache_pkg::size_double);
        cache_write(32'h6011, dcache_pkg::size_byte, 64'hffff_ffff_ffff_ffa5);  // Upper bytes ignored
        cache_write(32'h6012, dcache_pkg::size_half, 64'h5555_5555_5555_1234);
        cache_write(32'h6014, dcache_pkg::size_word, 64'h7777_7777_dead_beef);
        cache_read_check("write_merge", 32'h6010, dcache_pkg::size_double);
    endtask

    task automatic test_write_allocate();
        cache_write(32'h7a94, dcache_pkg::size_word, 64'h0000_0000_0bad_f00d);
        cache_read_check("write_allocate", 32'h7a94, dcache_pkg::size_word);
        cache_read_check("write_allocate", 32'h7a90, dcache_pkg::size_word);
        cache_read_check("write_allocate", 32'h7a98, dcache_pkg::size_double);
    endtask

    // Three more lines of the same set push line A out of both ways
    task automatic test_dirty_eviction(input logic [31:0] base, input logic [63:0] value);
        cache_write(base + 32'h8, dcache_pkg::size_double, value);
        cache_read_check("dirty_eviction", base + 32'h108, dcache_pkg::size_double);
        cache_read_check("dirty_eviction", base + 32'h208, dcache_pkg::size_double);
        cache_read_check("dirty_eviction", base + 32'h308, dcache_pkg::size_double);
        // Line A must now sit in memory
        compare("dirty_eviction write-back", expected_word(base + 32'h8),
                u_axi_mem_model.mem_read(base + 32'h8));
        cache_read_check("dirty_eviction", base + 32'h8, dcache_pkg::size_double);
        cache_read_check("dirty_eviction", base, dcache_pkg::size_double);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        req = '0;
        stalls = 1'b0;
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        @(posedge clock);
        #1;
        test_miss_then_hit(32'h0000_1000);
        test_read_sizes();
        test_write_merge();
        test_write_allocate();
        test_dirty_eviction(32'h0000_8000, 64'hc0ff_ee00_1122_3344);
        stalls = 1'b1;                      // Random stalls on every channel
        test_miss_then_hit(32'h0004_0000);
        test_dirty_eviction(32'h0005_0040, 64'h8bad_f00d_55aa_33cc);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/dcache_pkg.sv
design/tag_array.sv
design/line_store.sv
design/cache_ctrl.sv
design/dcache_top.sv
sim/axi_mem_model.sv
sim/dcache_props.sv
sim/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache -f tb.f -o sim_dcache

status=0
./obj_dir/sim_dcache > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
